// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    // ==================================================================
    // Widths and basic types
    // ==================================================================
    typedef logic [15:0] word_t;
    typedef logic [15:0] instr_t;
    typedef logic [7:0]  addr_t;
    typedef logic [3:0]  reg_idx_t;

    // Opcodes live in bits 15..12
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_ADD   = 4'h1,
        OP_CMP   = 4'h2,
        OP_LOAD  = 4'h3,
        OP_STORE = 4'h4,
        OP_BZ    = 4'h5,
        OP_HALT  = 4'h7,
        OP_ADDI  = 4'h8,
        OP_SUB   = 4'hd
    } opcode_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } run_state_e;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_MEM = 2'b01,
        FWD_WB  = 2'b10
    } fwd_sel_e;

    localparam instr_t NOP_INSTR = 16'h0000;

    // ==================================================================
    // Instruction classes
    // ==================================================================
    function automatic opcode_e op_of(instr_t instr);
        return opcode_e'(instr[15:12]);
    endfunction

    function automatic logic writes_reg(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_CMP, OP_ADDI, OP_LOAD};
    endfunction

    function automatic logic sets_zero(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_CMP, OP_ADDI};
    endfunction

    function automatic logic reads_rs2(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_CMP};
    endfunction

    // ADDI accumulates into rd
    function automatic reg_idx_t rs1_of(instr_t instr);
        return (op_of(instr) == OP_ADDI) ? instr[11:8] : instr[7:4];
    endfunction

endpackage

// ==== core/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter cpu_pkg::addr_t RESET_PC = 8'h00
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              halt_wb,
    input  logic              stall,
    input  logic              branch_taken,
    input  cpu_pkg::addr_t    branch_target,
    input  cpu_pkg::instr_t   instruction,
    output cpu_pkg::addr_t    i_addr,
    output cpu_pkg::instr_t   instr_id,
    output logic              running
);

    cpu_pkg::run_state_e state;
    cpu_pkg::run_state_e state_next;

    // ==================================================================
    // Run control
    // ==================================================================
    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::ST_IDLE: if (start) state_next = cpu_pkg::ST_RUN;
            cpu_pkg::ST_RUN:  if (halt_wb) state_next = cpu_pkg::ST_IDLE;
            default:          state_next = cpu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign running = (state == cpu_pkg::ST_RUN);

    // ==================================================================
    // Program counter and fetch-to-decode register
    // ==================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            i_addr   <= RESET_PC;
            instr_id <= cpu_pkg::NOP_INSTR;
        end else if (running) begin
            if (branch_taken) begin
                // Redirect and drop the instruction fetched this cycle
                i_addr   <= branch_target;
                instr_id <= cpu_pkg::NOP_INSTR;
            end else if (!stall) begin
                i_addr   <= i_addr + 8'd1;
                instr_id <= instruction;
            end
            // Load-use stall holds both
        end
    end

endmodule

// ==== core/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  cpu_pkg::reg_idx_t   wr_idx,
    input  cpu_pkg::word_t      wr_data,
    input  cpu_pkg::reg_idx_t   rd_idx_a,
    input  cpu_pkg::reg_idx_t   rd_idx_b,
    input  cpu_pkg::reg_idx_t   rd_idx_s,
    output cpu_pkg::word_t      rd_a,
    output cpu_pkg::word_t      rd_b,
    output cpu_pkg::word_t      rd_s,
    output cpu_pkg::word_t      r15
);

    cpu_pkg::word_t regs [16];

    // Register 0 reads as zero and a write in flight is seen at once
    function automatic cpu_pkg::word_t read_port(cpu_pkg::reg_idx_t idx,
                                                 cpu_pkg::word_t stored);
        if (idx == 4'h0) begin
            return '0;
        end
        if (we && (idx == wr_idx)) begin
            return wr_data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_idx != 4'h0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_comb begin
        rd_a = read_port(rd_idx_a, regs[rd_idx_a]);
        rd_b = read_port(rd_idx_b, regs[rd_idx_b]);
        rd_s = read_port(rd_idx_s, regs[rd_idx_s]);
    end

    assign r15 = regs[15];

endmodule

// ==== core/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                running,
    input  logic                stall,
    input  logic                branch_taken,
    input  cpu_pkg::instr_t     instr_id,
    input  logic                wb_we,
    input  cpu_pkg::reg_idx_t   wb_idx,
    input  cpu_pkg::word_t      wb_data,
    output cpu_pkg::instr_t     instr_ex,
    output cpu_pkg::word_t      op_a,
    output cpu_pkg::word_t      op_b,
    output cpu_pkg::word_t      op_s,
    output cpu_pkg::word_t      r15
);

    cpu_pkg::opcode_e   op_id;
    cpu_pkg::reg_idx_t  idx_a;
    cpu_pkg::reg_idx_t  idx_b;
    cpu_pkg::reg_idx_t  idx_s;
    cpu_pkg::word_t     val_a;
    cpu_pkg::word_t     val_b;
    cpu_pkg::word_t     val_s;
    logic               bubble;

    // Source register selection
    assign op_id = cpu_pkg::op_of(instr_id);
    assign idx_a = cpu_pkg::rs1_of(instr_id);
    assign idx_b = cpu_pkg::reads_rs2(op_id) ? instr_id[3:0] : 4'h0;
    // STORE keeps its data register in the rd field
    assign idx_s = instr_id[11:8];

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .we       (wb_we),
        .wr_idx   (wb_idx),
        .wr_data  (wb_data),
        .rd_idx_a (idx_a),
        .rd_idx_b (idx_b),
        .rd_idx_s (idx_s),
        .rd_a     (val_a),
        .rd_b     (val_b),
        .rd_s     (val_s),
        .r15      (r15)
    );

    assign bubble = branch_taken || stall;

    // ==================================================================
    // Decode-to-execute register
    // ==================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_ex <= cpu_pkg::NOP_INSTR;
        end else if (running) begin
            instr_ex <= bubble ? cpu_pkg::NOP_INSTR : instr_id;
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            op_a <= bubble ? '0 : val_a;
            op_b <= bubble ? '0 : val_b;
            op_s <= bubble ? '0 : val_s;
        end
    end

endmodule

// ==== core/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::instr_t     instr_id,
    input  cpu_pkg::instr_t     instr_ex,
    input  cpu_pkg::instr_t     instr_mem,
    input  cpu_pkg::instr_t     instr_wb,
    output logic                stall,
    output cpu_pkg::fwd_sel_e   fwd_a,
    output cpu_pkg::fwd_sel_e   fwd_b,
    output cpu_pkg::fwd_sel_e   fwd_s
);

    cpu_pkg::opcode_e   op_id;
    cpu_pkg::reg_idx_t  load_rd;
    logic               ex_is_load;
    logic               id_uses_rs1;

    // Memory stage is younger than write-back, so it wins
    function automatic cpu_pkg::fwd_sel_e source_of(cpu_pkg::reg_idx_t src,
                                                    cpu_pkg::instr_t mem,
                                                    cpu_pkg::instr_t wb);
        if (cpu_pkg::writes_reg(cpu_pkg::op_of(mem)) && (mem[11:8] != 4'h0)
                && (mem[11:8] == src)) begin
            return cpu_pkg::FWD_MEM;
        end
        if (cpu_pkg::writes_reg(cpu_pkg::op_of(wb)) && (wb[11:8] != 4'h0)
                && (wb[11:8] == src)) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_REG;
    endfunction

    // ==================================================================
    // Load-use detection
    // ==================================================================
    assign op_id       = cpu_pkg::op_of(instr_id);
    assign load_rd     = instr_ex[11:8];
    assign ex_is_load  = (cpu_pkg::op_of(instr_ex) == cpu_pkg::OP_LOAD) && (load_rd != 4'h0);
    assign id_uses_rs1 = op_id inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_CMP,
                                       cpu_pkg::OP_ADDI, cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE};

    assign stall = ex_is_load && (
        (id_uses_rs1 && (cpu_pkg::rs1_of(instr_id) == load_rd)) ||
        (cpu_pkg::reads_rs2(op_id) && (instr_id[3:0] == load_rd)) ||
        ((op_id == cpu_pkg::OP_STORE) && (instr_id[11:8] == load_rd)));

    // Operand sources for the instruction in execute
    assign fwd_a = source_of(cpu_pkg::rs1_of(instr_ex), instr_mem, instr_wb);
    assign fwd_b = source_of(instr_ex[3:0], instr_mem, instr_wb);
    assign fwd_s = source_of(instr_ex[11:8], instr_mem, instr_wb);

endmodule

// ==== core/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                running,
    input  logic                branch_taken,
    input  cpu_pkg::instr_t     instr_ex,
    input  cpu_pkg::word_t      op_a,
    input  cpu_pkg::word_t      op_b,
    input  cpu_pkg::word_t      op_s,
    input  cpu_pkg::fwd_sel_e   fwd_a,
    input  cpu_pkg::fwd_sel_e   fwd_b,
    input  cpu_pkg::fwd_sel_e   fwd_s,
    input  cpu_pkg::word_t      mem_result,
    input  cpu_pkg::word_t      wb_data,
    output cpu_pkg::instr_t     instr_mem,
    output cpu_pkg::word_t      alu_out,
    output cpu_pkg::word_t      store_data,
    output logic                zero_flag
);

    cpu_pkg::opcode_e   op_ex;
    cpu_pkg::word_t     a_fwd;
    cpu_pkg::word_t     b_fwd;
    cpu_pkg::word_t     s_fwd;
    cpu_pkg::word_t     alu_a;
    cpu_pkg::word_t     alu_b;
    cpu_pkg::word_t     alu_res;

    function automatic cpu_pkg::word_t pick(cpu_pkg::fwd_sel_e sel,
                                            cpu_pkg::word_t reg_val);
        case (sel)
            cpu_pkg::FWD_MEM: return mem_result;
            cpu_pkg::FWD_WB:  return wb_data;
            default:          return reg_val;
        endcase
    endfunction

    // ==================================================================
    // Forwarding and operand selection
    // ==================================================================
    assign op_ex = cpu_pkg::op_of(instr_ex);

    always_comb begin
        a_fwd = pick(fwd_a, op_a);
        b_fwd = pick(fwd_b, op_b);
        s_fwd = pick(fwd_s, op_s);
    end

    always_comb begin
        case (op_ex)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_CMP:
                alu_b = b_fwd;
            cpu_pkg::OP_ADDI:
                alu_b = {{8{instr_ex[7]}}, instr_ex[7:0]};
            cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE:
                alu_b = {12'h000, instr_ex[3:0]};
            cpu_pkg::OP_BZ:
                alu_b = {8'h00, instr_ex[7:0]};
            default:
                alu_b = '0;
        endcase
    end

    // Branch target passes through as 0 + target
    assign alu_a   = (op_ex == cpu_pkg::OP_BZ) ? '0 : a_fwd;
    assign alu_res = (op_ex inside {cpu_pkg::OP_SUB, cpu_pkg::OP_CMP}) ? alu_a - alu_b
                                                                        : alu_a + alu_b;

    // ==================================================================
    // Execute-to-memory register
    // ==================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_mem <= cpu_pkg::NOP_INSTR;
            zero_flag <= 1'b0;
        end else if (running) begin
            instr_mem <= branch_taken ? cpu_pkg::NOP_INSTR : instr_ex;
            if (!branch_taken && cpu_pkg::sets_zero(op_ex)) begin
                zero_flag <= (alu_res == '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            alu_out    <= alu_res;
            store_data <= s_fwd;
        end
    end

endmodule

// ==== core/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                running,
    input  cpu_pkg::instr_t     instr_mem,
    input  cpu_pkg::word_t      alu_out,
    input  cpu_pkg::word_t      store_data,
    input  logic                zero_flag,
    input  cpu_pkg::word_t      d_rdata,
    output cpu_pkg::addr_t      d_addr,
    output cpu_pkg::word_t      d_wdata,
    output logic                d_we,
    output logic                branch_taken,
    output cpu_pkg::addr_t      branch_target,
    output cpu_pkg::instr_t     instr_wb,
    output logic                wb_we,
    output cpu_pkg::reg_idx_t   wb_idx,
    output cpu_pkg::word_t      wb_data,
    output logic                halt_wb
);

    cpu_pkg::opcode_e op_mem;
    cpu_pkg::opcode_e op_wb;

    assign op_mem = cpu_pkg::op_of(instr_mem);
    assign op_wb  = cpu_pkg::op_of(instr_wb);

    // Data port
    assign d_addr  = alu_out[7:0];
    assign d_wdata = store_data;
    // A store behind a HALT is dropped
    assign d_we    = running && (op_mem == cpu_pkg::OP_STORE) && !halt_wb;

    assign branch_taken  = (op_mem == cpu_pkg::OP_BZ) && zero_flag;
    assign branch_target = alu_out[7:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_wb <= cpu_pkg::NOP_INSTR;
        end else if (running) begin
            instr_wb <= instr_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            wb_data <= (op_mem == cpu_pkg::OP_LOAD) ? d_rdata : alu_out;
        end
    end

    // Write-back controls
    assign wb_we   = running && cpu_pkg::writes_reg(op_wb);
    assign wb_idx  = instr_wb[11:8];
    assign halt_wb = (op_wb == cpu_pkg::OP_HALT);

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::addr_t RESET_PC = 8'h00
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  cpu_pkg::instr_t   instruction,
    input  cpu_pkg::word_t    d_rdata,
    output cpu_pkg::addr_t    i_addr,
    output cpu_pkg::addr_t    d_addr,
    output cpu_pkg::word_t    d_wdata,
    output logic              d_we,
    output cpu_pkg::word_t    result,
    output logic              running
);

    // Pipeline instructions
    cpu_pkg::instr_t    instr_id;
    cpu_pkg::instr_t    instr_ex;
    cpu_pkg::instr_t    instr_mem;
    cpu_pkg::instr_t    instr_wb;

    // Datapath between stages
    cpu_pkg::word_t     op_a;
    cpu_pkg::word_t     op_b;
    cpu_pkg::word_t     op_s;
    cpu_pkg::word_t     alu_out;
    cpu_pkg::word_t     store_data;
    logic               zero_flag;
    cpu_pkg::word_t     wb_data;
    cpu_pkg::reg_idx_t  wb_idx;
    logic               wb_we;

    // Control
    logic               stall;
    logic               branch_taken;
    cpu_pkg::addr_t     branch_target;
    logic               halt_wb;
    cpu_pkg::fwd_sel_e  fwd_a;
    cpu_pkg::fwd_sel_e  fwd_b;
    cpu_pkg::fwd_sel_e  fwd_s;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .reset(reset), .start(start), .halt_wb(halt_wb), .stall(stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .instruction(instruction), .i_addr(i_addr), .instr_id(instr_id), .running(running)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset), .running(running), .stall(stall),
        .branch_taken(branch_taken), .instr_id(instr_id), .wb_we(wb_we), .wb_idx(wb_idx),
        .wb_data(wb_data), .instr_ex(instr_ex), .op_a(op_a), .op_b(op_b), .op_s(op_s),
        .r15(result)
    );

    hazard_unit u_hazard (
        .instr_id(instr_id), .instr_ex(instr_ex), .instr_mem(instr_mem),
        .instr_wb(instr_wb), .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_s(fwd_s)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset), .running(running), .branch_taken(branch_taken),
        .instr_ex(instr_ex), .op_a(op_a), .op_b(op_b), .op_s(op_s),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .fwd_s(fwd_s), .mem_result(alu_out),
        .wb_data(wb_data), .instr_mem(instr_mem), .alu_out(alu_out),
        .store_data(store_data), .zero_flag(zero_flag)
    );

    memory_stage u_memory (
        .clk(clk), .reset(reset), .running(running), .instr_mem(instr_mem),
        .alu_out(alu_out), .store_data(store_data), .zero_flag(zero_flag),
        .d_rdata(d_rdata), .d_addr(d_addr), .d_wdata(d_wdata), .d_we(d_we),
        .branch_taken(branch_taken), .branch_target(branch_target), .instr_wb(instr_wb),
        .wb_we(wb_we), .wb_idx(wb_idx), .wb_data(wb_data), .halt_wb(halt_wb)
    );

endmodule

// ==== tb/cpu_props.sv ====
`timescale 1ns/1ps

module cpu_props (
    input logic           clk,
    input logic           reset,
    input logic           start,
    input logic           running,
    input logic           d_we,
    input cpu_pkg::addr_t i_addr
);

    // High from reset until the first start
    logic armed;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            armed <= 1'b1;
        end else if (start) begin
            armed <= 1'b0;
        end
    end

    // ==================================================================
    // Port properties
    // ==================================================================
    assert property (@(posedge clk) disable iff (reset) !running |-> !d_we)
        else $error("d_we high while idle");

    assert property (@(posedge clk) disable iff (reset) !running |=> $stable(i_addr))
        else $error("i_addr moved while idle");

    assert property (@(posedge clk) disable iff (reset) armed |-> !d_we)
        else $error("d_we high before start");

endmodule

bind cpu_top cpu_props u_props (
    .clk(clk), .reset(reset), .start(start), .running(running), .d_we(d_we), .i_addr(i_addr)
);

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam int NUM_TESTS    = 8;
    localparam int RESET_CYCLES = 5;
    localparam int WATCHDOG_NS  = NUM_TESTS * (40 + RESET_CYCLES + 8) * 20;

    logic            clk = 1'b0;
    logic            reset;
    logic            start;
    cpu_pkg::instr_t instruction;
    cpu_pkg::word_t  d_rdata;
    cpu_pkg::addr_t  i_addr;
    cpu_pkg::addr_t  d_addr;
    cpu_pkg::word_t  d_wdata;
    logic            d_we;
    cpu_pkg::word_t  result;
    logic            running;

    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] exp_mem [256];

    // ==================================================================
    // Test table
    // ==================================================================
    logic [15:0] prog_tab [NUM_TESTS][16];
    logic [7:0]  init_addr_tab [NUM_TESTS];
    logic [15:0] init_word_tab [NUM_TESTS];
    logic [7:0]  chk_addr_tab [NUM_TESTS];
    bit          rnd_tab [NUM_TESTS];
    int          holds_tab [NUM_TESTS];
    logic [15:0] exp_result_tab [NUM_TESTS];
    logic [15:0] exp_word_tab [NUM_TESTS];

    logic [31:0] lcg_state = 32'h6b87;
    int          hold_count;
    logic [7:0]  prev_addr;
    logic        was_running = 1'b0;

    cpu_top u_dut (
        .clk(clk), .reset(reset), .start(start), .instruction(instruction),
        .d_rdata(d_rdata), .i_addr(i_addr), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_we(d_we), .result(result), .running(running)
    );

    always #10 clk = ~clk;

    // Combinational memories
    assign instruction = imem[i_addr];
    assign d_rdata     = dmem[d_addr];

    always @(posedge clk) begin
        if (d_we) begin
            dmem[d_addr] <= d_wdata;
        end
    end

    function automatic logic [15:0] enc_reg(logic [3:0] op, logic [3:0] rd,
                                            logic [3:0] rs1, logic [3:0] rs2);
        return {op, rd, rs1, rs2};
    endfunction

    function automatic logic [15:0] enc_imm(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic build_table();
        logic [15:0] chain [16];
        chain = '{0: enc_imm(cpu_pkg::OP_ADDI, 15, 8'h00), 1: enc_imm(cpu_pkg::OP_ADDI, 1, 8'h00),
                  2: enc_reg(cpu_pkg::OP_ADD, 15, 15, 1), 3: enc_imm(cpu_pkg::OP_ADDI, 15, 8'h00),
                  4: enc_reg(cpu_pkg::OP_SUB, 15, 15, 1), 5: enc_imm(cpu_pkg::OP_ADDI, 1, 8'h00),
                  6: enc_reg(cpu_pkg::OP_ADD, 15, 15, 1), 7: 16'h7000, default: 16'h0000};
        // Dependent ALU chain
        prog_tab[0] = '{0: enc_imm(cpu_pkg::OP_ADDI, 1, 8'h05), 1: enc_imm(cpu_pkg::OP_ADDI, 1, 8'h03),
                        2: enc_reg(cpu_pkg::OP_ADD, 2, 1, 1), 3: enc_reg(cpu_pkg::OP_SUB, 3, 2, 1),
                        4: enc_reg(cpu_pkg::OP_ADD, 15, 3, 2), 5: 16'h7000, default: 16'h0000};
        // Load then immediate use
        prog_tab[1] = '{0: enc_imm(cpu_pkg::OP_ADDI, 1, 8'h07), 1: enc_reg(cpu_pkg::OP_LOAD, 2, 1, 3),
                        2: enc_reg(cpu_pkg::OP_ADD, 15, 2, 2), 3: 16'h7000, default: 16'h0000};
        // Store of a just-written register and a read back
        prog_tab[2] = '{0: enc_imm(cpu_pkg::OP_ADDI, 4, 8'h21), 1: enc_imm(cpu_pkg::OP_ADDI, 5, 8'h30),
                        2: enc_reg(cpu_pkg::OP_ADD, 6, 4, 5), 3: enc_reg(cpu_pkg::OP_STORE, 6, 5, 2),
                        4: enc_reg(cpu_pkg::OP_LOAD, 15, 5, 2), 5: 16'h7000, default: 16'h0000};
        // Equal operands take the branch over three instructions
        prog_tab[3] = '{0: enc_imm(cpu_pkg::OP_ADDI, 1, 8'h04), 1: enc_imm(cpu_pkg::OP_ADDI, 2, 8'h04),
                        2: enc_reg(cpu_pkg::OP_CMP, 3, 1, 2), 3: enc_imm(cpu_pkg::OP_BZ, 0, 8'h08),
                        4: enc_imm(cpu_pkg::OP_ADDI, 15, 8'h01), 5: enc_reg(cpu_pkg::OP_STORE, 1, 0, 9),
                        6: enc_imm(cpu_pkg::OP_ADDI, 15, 8'h02),
                        8: enc_imm(cpu_pkg::OP_ADDI, 15, 8'h40), 9: 16'h7000, default: 16'h0000};
        // Unequal operands fall through
        prog_tab[4] = prog_tab[3];
        prog_tab[4][1] = enc_imm(cpu_pkg::OP_ADDI, 2, 8'h05);
        prog_tab[4][5] = enc_reg(cpu_pkg::OP_STORE, 15, 0, 9);
        prog_tab[4][6] = 16'h7000;
        // Writes to register 0 are dropped
        prog_tab[5] = '{0: enc_imm(cpu_pkg::OP_ADDI, 0, 8'h55), 1: enc_reg(cpu_pkg::OP_ADD, 15, 0, 0),
                        2: enc_imm(cpu_pkg::OP_ADDI, 15, 8'h11), 3: enc_reg(cpu_pkg::OP_ADD, 15, 15, 0),
                        4: 16'h7000, default: 16'h0000};
        prog_tab[6] = chain;
        prog_tab[7] = chain;
        init_addr_tab = '{8'h10, 8'h0a, 8'h32, 8'h09, 8'h09, 8'h00, 8'h20, 8'h21};
        init_word_tab = '{16'hbeef, 16'h1234, 16'h0000, 16'h0777, 16'h0777, 16'h0000,
                          16'h0001, 16'h0002};
        chk_addr_tab  = '{8'h10, 8'h0a, 8'h32, 8'h09, 8'h09, 8'h00, 8'h20, 8'h21};
        rnd_tab       = '{0, 0, 0, 0, 0, 0, 1, 1};
        holds_tab     = '{0, 1, 0, 0, 0, 0, 0, 0};
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < 16; i++) begin
                if (rnd_tab[t] && prog_tab[t][i][15:12] == cpu_pkg::OP_ADDI) begin
                    prog_tab[t][i][7:0] = lcg_next() >> 16;
                end
            end
        end
    endtask

    // Sequential instruction-set model stepping one instruction at a time
    task automatic run_model(int t);
        logic [15:0] r [16];
        logic [15:0] w;
        logic [15:0] res;
        logic [7:0]  pc;
        logic [7:0]  ea;
        logic        z;
        bit          halted;
        int          steps;
        r = '{default: 16'h0000};
        pc = 8'h00;
        z = 1'b0;
        halted = 0;
        steps = 0;
        for (int a = 0; a < 256; a++) begin
            exp_mem[a] = dmem[a];
        end
        while (!halted && steps < 64) begin
            w = imem[pc];
            pc = pc + 8'd1;
            ea = r[w[7:4]] + {12'h000, w[3:0]};
            case (w[15:12])
                cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_CMP, cpu_pkg::OP_ADDI: begin
                    if (w[15:12] == cpu_pkg::OP_ADD) res = r[w[7:4]] + r[w[3:0]];
                    else if (w[15:12] == cpu_pkg::OP_ADDI) res = r[w[11:8]] + {{8{w[7]}}, w[7:0]};
                    else res = r[w[7:4]] - r[w[3:0]];
                    r[w[11:8]] = res;
                    z = (res == 16'h0000);
                end
                cpu_pkg::OP_LOAD:  r[w[11:8]] = exp_mem[ea];
                cpu_pkg::OP_STORE: exp_mem[ea] = r[w[11:8]];
                cpu_pkg::OP_BZ:    if (z) pc = w[7:0];
                cpu_pkg::OP_HALT:  halted = 1;
                default: ;
            endcase
            r[0] = 16'h0000;
            steps++;
        end
        exp_result_tab[t] = r[15];
        exp_word_tab[t]   = exp_mem[chk_addr_tab[t]];
    endtask

    // Fetch-hold counting and store checks
    always @(negedge clk) begin
        if (running && was_running && i_addr == prev_addr) begin
            hold_count++;
        end
        if (d_we) begin
            assert (d_wdata === exp_mem[d_addr]) else begin
                $display("Error: d_wdata = %h at d_addr %h, expected %h",
                         d_wdata, d_addr, exp_mem[d_addr]);
                abort_run();
            end
        end
        prev_addr   <= i_addr;
        was_running <= running;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, a program did not reach HALT in time");
        $display("tests failed");
        $fatal(1);
    end

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        logic [15:0] final_result;
        reset = 1'b1;
        start = 1'b0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            reset = 1'b1;
            for (int a = 0; a < 256; a++) begin
                imem[a] = (a < 16) ? prog_tab[t][a] : 16'h0000;
                dmem[a] = {a[7:0], ~a[7:0]};
            end
            dmem[init_addr_tab[t]] = init_word_tab[t];
            run_model(t);
            repeat (RESET_CYCLES) @(negedge clk);
            reset = 1'b0;
            assert (!running && !d_we && i_addr == 8'h00 && result == 16'h0000) else begin
                $display("Error: after reset running = %h, d_we = %h, i_addr = %h, result = %h (test %0d)",
                         running, d_we, i_addr, result, t);
                abort_run();
            end
            hold_count = 0;
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            assert (running) else begin
                $display("Core did not start in test %0d", t);
                abort_run();
            end
            while (running) @(negedge clk);
            assert (result === exp_result_tab[t]) else begin
                $display("Error: result = %h, expected %h (test %0d)",
                         result, exp_result_tab[t], t);
                abort_run();
            end
            assert (dmem[chk_addr_tab[t]] === exp_word_tab[t]) else begin
                $display("Error: dmem[%h] = %h, expected %h (test %0d)", chk_addr_tab[t],
                         dmem[chk_addr_tab[t]], exp_word_tab[t], t);
                abort_run();
            end
            assert (hold_count == holds_tab[t]) else begin
                $display("Error: fetch holds = %h, expected %h (test %0d)",
                         hold_count, holds_tab[t], t);
                abort_run();
            end
            final_result = result;
            repeat (3) @(negedge clk);
            assert (result === final_result && !running) else begin
                $display("Error: result = %h, expected %h, running = %h after HALT (test %0d)",
                         result, final_result, running, t);
                abort_run();
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
common/cpu_pkg.sv
core/fetch_unit.sv
core/reg_file.sv
core/decode_stage.sv
core/hazard_unit.sv
core/execute_stage.sv
core/memory_stage.sv
verilog/cpu_top.sv
tb/cpu_props.sv
tb/cpu_tb.sv
